//--- compile.f
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/cpu_sequencer.sv
hdl/cpu_execute.sv
hdl/cpu_bus_unit.sv
hdl/cpu_core.sv
tests/cpu_checker.sv
tests/tb_cpu_core.sv

//--- hdl/cpu_bus_unit.sv
`timescale 1ns/1ps

module cpu_bus_unit (
    input  cpu_ctrl_pkg::seq_state_e i_state,
    input  logic [15:0]              i_pc,
    input  logic [15:0]              i_store_addr,
    input  cpu_ctrl_pkg::reg_dst_e   i_store_src,
    input  logic [7:0]               i_a,
    input  logic [7:0]               i_x,
    input  logic [7:0]               i_y,
    output logic [15:0]              o_addr,
    output logic                     o_mem_r_en,
    output logic [7:0]               o_w_data
);

    import cpu_ctrl_pkg::*;

    logic [7:0] store_byte;

    // register picked for the store cycle
    always_comb begin
        case (i_store_src)
            DST_A:   store_byte = i_a;
            DST_X:   store_byte = i_x;
            DST_Y:   store_byte = i_y;
            default: store_byte = 8'd0;
        endcase
    end

    // only the store cycle writes, every other cycle reads at the pc
    always_comb begin
        if (i_state == ST_STORE) begin
            o_addr     = i_store_addr;
            o_mem_r_en = 1'b0;
            o_w_data   = store_byte;
        end else begin
            o_addr     = i_pc;
            o_mem_r_en = 1'b1;
            o_w_data   = 8'd0;
        end
    end

endmodule : cpu_bus_unit

//--- hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0400
) (
    input  logic        i_clock,
    input  logic        i_reset_active,
    input  logic        i_clock_en,
    input  logic [7:0]  i_r_data,
    output logic [15:0] o_addr,
    output logic        o_mem_r_en,
    output logic [7:0]  o_w_data
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    seq_state_e   state;
    logic [15:0]  pc;
    logic [15:0]  store_addr;
    reg_dst_e     store_src;
    alu_op_e      alu_op;
    reg_dst_e     dst;
    logic [7:0]   operand;
    logic         exec_en;
    logic         set_carry;
    logic         clr_carry;
    logic         is_branch;
    branch_flag_e branch_flag;
    logic         branch_value;
    logic         take_branch;
    logic [7:0]   reg_a;
    logic [7:0]   reg_x;
    logic [7:0]   reg_y;

    cpu_sequencer #(.RESET_PC(RESET_PC)) cpu_sequencer_inst (
        .i_clock        (i_clock),
        .i_reset_active (i_reset_active),
        .i_clock_en     (i_clock_en),
        .i_r_data       (i_r_data),
        .i_take_branch  (take_branch),
        .o_state        (state),
        .o_pc           (pc),
        .o_store_addr   (store_addr),
        .o_store_src    (store_src),
        .o_alu_op       (alu_op),
        .o_dst          (dst),
        .o_operand      (operand),
        .o_exec_en      (exec_en),
        .o_set_carry    (set_carry),
        .o_clr_carry    (clr_carry),
        .o_is_branch    (is_branch),
        .o_branch_flag  (branch_flag),
        .o_branch_value (branch_value)
    );

    cpu_execute cpu_execute_inst (
        .i_clock        (i_clock),
        .i_reset_active (i_reset_active),
        .i_clock_en     (i_clock_en),
        .i_alu_op       (alu_op),
        .i_dst          (dst),
        .i_operand      (operand),
        .i_exec_en      (exec_en),
        .i_set_carry    (set_carry),
        .i_clr_carry    (clr_carry),
        .i_is_branch    (is_branch),
        .i_branch_flag  (branch_flag),
        .i_branch_value (branch_value),
        .o_a            (reg_a),
        .o_x            (reg_x),
        .o_y            (reg_y),
        .o_take_branch  (take_branch)
    );

    cpu_bus_unit cpu_bus_unit_inst (
        .i_state      (state),
        .i_pc         (pc),
        .i_store_addr (store_addr),
        .i_store_src  (store_src),
        .i_a          (reg_a),
        .i_x          (reg_x),
        .i_y          (reg_y),
        .o_addr       (o_addr),
        .o_mem_r_en   (o_mem_r_en),
        .o_w_data     (o_w_data)
    );

endmodule : cpu_core

//--- hdl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    //////////////////////////////////////////////////
    // instruction cycle

    // FETCH reads the opcode, OPERAND the next byte
    typedef enum logic [2:0] {
        ST_FETCH   = 3'd0,
        ST_OPERAND = 3'd1,
        ST_ADDR_HI = 3'd2,
        ST_STORE   = 3'd3,
        ST_BRANCH  = 3'd4
    } seq_state_e;

    //////////////////////////////////////////////////
    // execute controls

    typedef enum logic [2:0] {
        ALU_PASS = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_CMP  = 3'd6,
        ALU_HOLD = 3'd7
    } alu_op_e;

    // result destination, also the store source
    typedef enum logic [1:0] {
        DST_NONE = 2'd0,
        DST_A    = 2'd1,
        DST_X    = 2'd2,
        DST_Y    = 2'd3
    } reg_dst_e;

endpackage : cpu_ctrl_pkg

//--- hdl/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
    input  logic                      i_clock,
    input  logic                      i_reset_active,
    input  logic                      i_clock_en,
    input  cpu_ctrl_pkg::alu_op_e     i_alu_op,
    input  cpu_ctrl_pkg::reg_dst_e    i_dst,
    input  logic [7:0]                i_operand,
    input  logic                      i_exec_en,
    input  logic                      i_set_carry,
    input  logic                      i_clr_carry,
    input  logic                      i_is_branch,
    input  cpu_isa_pkg::branch_flag_e i_branch_flag,
    input  logic                      i_branch_value,
    output logic [7:0]                o_a,
    output logic [7:0]                o_x,
    output logic [7:0]                o_y,
    output logic                      o_take_branch
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [7:0] reg_a;
    logic [7:0] reg_x;
    logic [7:0] reg_y;
    logic       n_flag;
    logic       v_flag;
    logic       z_flag;
    logic       c_flag;

    logic [7:0] operand_b;
    logic       carry_in;
    logic [8:0] sum;
    logic [7:0] alu_result;
    logic       alu_v;
    logic       nz_en;
    logic       c_en;
    logic       v_en;
    logic       flag_bit;

    //////////////////////////////////////////////////
    // ALU

    // subtract and compare add the inverted operand
    assign operand_b = (i_alu_op == ALU_SUB || i_alu_op == ALU_CMP) ? ~i_operand : i_operand;
    assign carry_in  = (i_alu_op == ALU_CMP) ? 1'b1 : c_flag;
    assign sum       = {1'b0, reg_a} + {1'b0, operand_b} + {8'd0, carry_in};

    // signed overflow: same input signs, different result sign
    assign alu_v = (reg_a[7] == operand_b[7]) && (sum[7] != reg_a[7]);

    always_comb begin
        case (i_alu_op)
            ALU_PASS: alu_result = i_operand;
            ALU_ADD:  alu_result = sum[7:0];
            ALU_SUB:  alu_result = sum[7:0];
            ALU_CMP:  alu_result = sum[7:0];
            ALU_AND:  alu_result = reg_a & i_operand;
            ALU_OR:   alu_result = reg_a | i_operand;
            ALU_XOR:  alu_result = reg_a ^ i_operand;
            default:  alu_result = reg_a;
        endcase
    end

    assign nz_en = (i_alu_op != ALU_HOLD);
    assign c_en  = (i_alu_op == ALU_ADD || i_alu_op == ALU_SUB || i_alu_op == ALU_CMP);
    assign v_en  = (i_alu_op == ALU_ADD || i_alu_op == ALU_SUB);

    //////////////////////////////////////////////////
    // registers and flags

    always_ff @(posedge i_clock) begin
        if (i_reset_active) begin
            reg_a  <= 8'd0;
            reg_x  <= 8'd0;
            reg_y  <= 8'd0;
            n_flag <= 1'b0;
            v_flag <= 1'b0;
            z_flag <= 1'b0;
            c_flag <= 1'b0;
        end else if (i_clock_en && i_exec_en) begin
            case (i_dst)
                DST_A:   reg_a <= alu_result;
                DST_X:   reg_x <= alu_result;
                DST_Y:   reg_y <= alu_result;
                default: ;
            endcase
            if (nz_en) begin
                n_flag <= alu_result[7];
                z_flag <= (alu_result == 8'd0);
            end
            if (v_en) begin
                v_flag <= alu_v;
            end
            // CLC and SEC win over the ALU carry
            if (i_set_carry) begin
                c_flag <= 1'b1;
            end else if (i_clr_carry) begin
                c_flag <= 1'b0;
            end else if (c_en) begin
                c_flag <= sum[8];
            end
        end
    end

    //////////////////////////////////////////////////
    // branch condition

    always_comb begin
        case (i_branch_flag)
            BR_N:    flag_bit = n_flag;
            BR_V:    flag_bit = v_flag;
            BR_C:    flag_bit = c_flag;
            default: flag_bit = z_flag;
        endcase
    end

    assign o_take_branch = i_is_branch && (flag_bit == i_branch_value);

    assign o_a = reg_a;
    assign o_x = reg_x;
    assign o_y = reg_y;

endmodule : cpu_execute

//--- hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    //////////////////////////////////////////////////
    // opcode fields

    // group-one operation in bits 7:5
    typedef enum logic [2:0] {
        AAA_ORA = 3'b000,
        AAA_AND = 3'b001,
        AAA_EOR = 3'b010,
        AAA_ADC = 3'b011,
        AAA_STA = 3'b100,
        AAA_LDA = 3'b101,
        AAA_CMP = 3'b110,
        AAA_SBC = 3'b111
    } aaa_e;

    // one opcode byte, read raw or as aaa/bbb/cc
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            aaa_e       aaa;
            logic [2:0] bbb;
            logic [1:0] cc;
        } fields;
    } opcode_u;

    localparam logic [1:0] CC_GROUP_ZERO = 2'b00;
    localparam logic [1:0] CC_GROUP_ONE  = 2'b01;

    localparam logic [2:0] BBB_IMM    = 3'b010;
    localparam logic [2:0] BBB_ABS    = 3'b011;
    localparam logic [2:0] BBB_BRANCH = 3'b100;

    // branch flag select, bits 7:6 of a branch opcode
    typedef enum logic [1:0] {
        BR_N = 2'b00,
        BR_V = 2'b01,
        BR_C = 2'b10,
        BR_Z = 2'b11
    } branch_flag_e;

    //////////////////////////////////////////////////
    // opcodes outside the group-one table

    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_STX_ABS = 8'h8E;
    localparam logic [7:0] OP_STY_ABS = 8'h8C;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_NOP     = 8'hEA;

endpackage : cpu_isa_pkg

//--- hdl/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer #(
    parameter logic [15:0] RESET_PC = 16'h0400
) (
    input  logic                       i_clock,
    input  logic                       i_reset_active,
    input  logic                       i_clock_en,
    input  logic [7:0]                 i_r_data,
    input  logic                       i_take_branch,
    output cpu_ctrl_pkg::seq_state_e   o_state,
    output logic [15:0]                o_pc,
    output logic [15:0]                o_store_addr,
    output cpu_ctrl_pkg::reg_dst_e     o_store_src,
    output cpu_ctrl_pkg::alu_op_e      o_alu_op,
    output cpu_ctrl_pkg::reg_dst_e     o_dst,
    output logic [7:0]                 o_operand,
    output logic                       o_exec_en,
    output logic                       o_set_carry,
    output logic                       o_clr_carry,
    output logic                       o_is_branch,
    output cpu_isa_pkg::branch_flag_e  o_branch_flag,
    output logic                       o_branch_value
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    seq_state_e  state_q;
    logic [15:0] pc_q;
    opcode_u     opcode_q;
    logic [7:0]  addr_lo_q;
    logic [7:0]  addr_hi_q;
    logic [2:0]  aaa_bits;

    // instruction class, drives the cycle sequence
    logic is_imm;
    logic is_store;
    logic is_jmp;

    //////////////////////////////////////////////////
    // decode

    always_comb begin
        is_imm      = 1'b0;
        is_store    = 1'b0;
        is_jmp      = 1'b0;
        o_is_branch = 1'b0;
        o_alu_op    = ALU_HOLD;
        o_dst       = DST_NONE;
        o_store_src = DST_NONE;
        o_set_carry = 1'b0;
        o_clr_carry = 1'b0;
        case (opcode_q.raw)
            OP_LDX_IMM: begin
                is_imm   = 1'b1;
                o_alu_op = ALU_PASS;
                o_dst    = DST_X;
            end
            OP_LDY_IMM: begin
                is_imm   = 1'b1;
                o_alu_op = ALU_PASS;
                o_dst    = DST_Y;
            end
            OP_STX_ABS: begin
                is_store    = 1'b1;
                o_store_src = DST_X;
            end
            OP_STY_ABS: begin
                is_store    = 1'b1;
                o_store_src = DST_Y;
            end
            OP_JMP_ABS: is_jmp = 1'b1;
            OP_CLC: o_clr_carry = 1'b1;
            OP_SEC: o_set_carry = 1'b1;
            OP_NOP: ;
            default: begin
                // field view, anything unmatched stays a one-byte no-op
                if (opcode_q.fields.cc == CC_GROUP_ONE && opcode_q.fields.bbb == BBB_IMM
                        && opcode_q.fields.aaa != AAA_STA) begin
                    is_imm = 1'b1;
                    o_dst  = DST_A;
                    case (opcode_q.fields.aaa)
                        AAA_ORA: o_alu_op = ALU_OR;
                        AAA_AND: o_alu_op = ALU_AND;
                        AAA_EOR: o_alu_op = ALU_XOR;
                        AAA_ADC: o_alu_op = ALU_ADD;
                        AAA_LDA: o_alu_op = ALU_PASS;
                        AAA_SBC: o_alu_op = ALU_SUB;
                        AAA_CMP: begin
                            o_alu_op = ALU_CMP;
                            o_dst    = DST_NONE;
                        end
                        default: o_alu_op = ALU_HOLD;
                    endcase
                end else if (opcode_q.fields.cc == CC_GROUP_ONE
                        && opcode_q.fields.bbb == BBB_ABS
                        && opcode_q.fields.aaa == AAA_STA) begin
                    is_store    = 1'b1;
                    o_store_src = DST_A;
                end else if (opcode_q.fields.cc == CC_GROUP_ZERO
                        && opcode_q.fields.bbb == BBB_BRANCH) begin
                    o_is_branch = 1'b1;
                end
            end
        endcase
    end

    // branch select lives in the aaa bits
    assign aaa_bits       = opcode_q.fields.aaa;
    assign o_branch_flag  = branch_flag_e'(aaa_bits[2:1]);
    assign o_branch_value = aaa_bits[0];

    assign o_operand    = i_r_data;
    assign o_exec_en    = (state_q == ST_OPERAND);
    assign o_state      = state_q;
    assign o_pc         = pc_q;
    assign o_store_addr = {addr_hi_q, addr_lo_q};

    //////////////////////////////////////////////////
    // state and program counter

    always_ff @(posedge i_clock) begin
        if (i_reset_active) begin
            state_q <= ST_FETCH;
            pc_q    <= RESET_PC;
        end else if (i_clock_en) begin
            case (state_q)
                ST_FETCH: begin
                    pc_q    <= pc_q + 16'd1;
                    state_q <= ST_OPERAND;
                end
                ST_OPERAND: begin
                    if (is_imm) begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= ST_FETCH;
                    end else if (is_store || is_jmp) begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= ST_ADDR_HI;
                    end else if (o_is_branch) begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= i_take_branch ? ST_BRANCH : ST_FETCH;
                    end else begin
                        // implied and unknown opcodes, dummy read
                        state_q <= ST_FETCH;
                    end
                end
                ST_ADDR_HI: begin
                    if (is_jmp) begin
                        pc_q <= {i_r_data, addr_lo_q};
                        state_q <= ST_FETCH;
                    end else begin
                        pc_q    <= pc_q + 16'd1;
                        state_q <= ST_STORE;
                    end
                end
                ST_BRANCH: begin
                    // pc already points past the offset byte
                    pc_q    <= pc_q + {{8{addr_lo_q[7]}}, addr_lo_q};
                    state_q <= ST_FETCH;
                end
                default: state_q <= ST_FETCH;
            endcase
        end
    end

    // opcode and address bytes
    always_ff @(posedge i_clock) begin
        if (i_clock_en) begin
            if (state_q == ST_FETCH) begin
                opcode_q.raw <= i_r_data;
            end
            if (state_q == ST_OPERAND) begin
                addr_lo_q <= i_r_data;
            end
            if (state_q == ST_ADDR_HI) begin
                addr_hi_q <= i_r_data;
            end
        end
    end

endmodule : cpu_sequencer

//--- run_sim.sh
#!/bin/sh
# build and run the cpu_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module tb_cpu_core \
    -o tb_cpu_core_sim

./obj_dir/tb_cpu_core_sim > sim.log
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

//--- tests/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
    input logic        i_clock,
    input logic        i_clock_en,
    input logic [15:0] i_addr,
    input logic        i_mem_r_en,
    input logic [7:0]  i_w_data
);

    logic [15:0] exp_addr[$];
    logic [7:0]  exp_data[$];
    logic [15:0] head_addr;
    logic [7:0]  head_data;
    string       test_name;
    logic        active = 1'b0;
    logic        marker_seen = 1'b0;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        marker_seen = 1'b0;
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic finish_test(input logic timed_out);
        active = 1'b0;
        if (timed_out) begin
            $display("%s: no write to 02ff before the timeout", test_name);
            test_errors++;
        end
        if (exp_addr.size() != 0) begin
            $display("%s: %0d expected writes never happened", test_name, exp_addr.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok", test_name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic report_counts();
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    endtask

    // a write is a rising edge with the enable high and the read enable low
    always @(posedge i_clock) begin
        if (active && i_clock_en && !i_mem_r_en) begin
            if (exp_addr.size() == 0) begin
                $display("%s: write to %h with data %h was not expected",
                    test_name, i_addr, i_w_data);
                test_errors++;
            end else begin
                head_addr = exp_addr.pop_front();
                head_data = exp_data.pop_front();
                if (head_addr != i_addr || head_data != i_w_data) begin
                    $display("[ERROR] %s: expected %h=%h actual %h=%h",
                        test_name, head_addr, head_data, i_addr, i_w_data);
                    test_errors++;
                end
            end
            if (i_addr == 16'h02FF) begin
                marker_seen = 1'b1;
            end
        end
    end

endmodule : cpu_checker

//--- tests/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

    localparam logic [15:0] RESET_PC = 16'h0400;
    localparam int NUM_ROWS = 10;
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clock = 1'b0;
    logic        reset_active;
    logic        clock_en = 1'b1;
    logic [7:0]  r_data;
    logic [15:0] addr;
    logic        mem_r_en;
    logic [7:0]  w_data;

    logic [7:0]  mem [0:65535];
    logic [15:0] lfsr_q = 16'd67;
    logic [15:0] asm_pc;
    logic        stall_mode = 1'b0;
    logic        timed_out = 1'b0;

    // program table
    // kind 0 is an ALU program, 1 stores registers and 2 tests control flow
    string      row_name  [NUM_ROWS];
    logic [7:0] row_op    [NUM_ROWS];
    logic [7:0] row_a     [NUM_ROWS];
    logic [7:0] row_b     [NUM_ROWS];
    logic       row_carry [NUM_ROWS];
    logic [7:0] row_x     [NUM_ROWS];
    logic       row_brval [NUM_ROWS];
    int         row_kind  [NUM_ROWS];

    cpu_core #(.RESET_PC(RESET_PC)) cpu_core_inst (
        .i_clock        (clock),
        .i_reset_active (reset_active),
        .i_clock_en     (clock_en),
        .i_r_data       (r_data),
        .o_addr         (addr),
        .o_mem_r_en     (mem_r_en),
        .o_w_data       (w_data)
    );

    cpu_checker checker_inst (
        .i_clock    (clock),
        .i_clock_en (clock_en),
        .i_addr     (addr),
        .i_mem_r_en (mem_r_en),
        .i_w_data   (w_data)
    );

    assign r_data = mem[addr];

    initial begin
        forever #4 clock = ~clock;
    end

    // low enable on about a quarter of the cycles when stalling
    always @(negedge clock) begin
        if (stall_mode) begin
            clock_en = (rand_bits(2) != 8'd0);
        end else begin
            clock_en = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // random numbers and assembler

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] value;
        logic       fb;
        value = 8'd0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            value  = {value[6:0], fb};
        end
        return value;
    endfunction

    task automatic put(input logic [7:0] b);
        mem[asm_pc] = b;
        asm_pc      = asm_pc + 16'd1;
    endtask

    // opcode followed by a one-byte argument
    task automatic put_op_arg(input logic [7:0] op, input logic [7:0] arg);
        put(op);
        put(arg);
    endtask

    task automatic put_abs(input logic [7:0] op, input logic [15:0] target);
        put(op);
        put(target[7:0]);
        put(target[15:8]);
    endtask

    //////////////////////////////////////////////////
    // expected values from the instruction rules

    function automatic logic branch_taken(input int flag_sel, input logic value,
            input logic n, input logic v, input logic c, input logic z);
        logic flag;
        case (flag_sel)
            0: flag = n;
            1: flag = v;
            2: flag = c;
            default: flag = z;
        endcase
        return flag == value;
    endfunction

    task automatic alu_program(input int r);
        logic [8:0] s;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] res;
        logic       n;
        logic       v;
        logic       z;
        logic       c;
        logic [7:0] br_op;
        int         flag_sel;
        a        = row_a[r];
        b        = row_b[r];
        c        = row_carry[r];
        v        = 1'b0;
        flag_sel = r % 4;
        br_op    = {2'(flag_sel), row_brval[r], 5'b10000};
        case (row_op[r])
            8'h69: begin
                s   = {1'b0, a} + {1'b0, b} + {8'd0, c};
                res = s[7:0];
                v   = (a[7] == b[7]) && (res[7] != a[7]);
                c   = s[8];
            end
            8'hE9: begin
                s   = {1'b0, a} + {1'b0, ~b} + {8'd0, c};
                res = s[7:0];
                v   = (a[7] != b[7]) && (res[7] != a[7]);
                c   = s[8];
            end
            8'hC9: begin
                s   = {1'b0, a} + {1'b0, ~b} + 9'd1;
                res = s[7:0];
                c   = s[8];
            end
            8'h29: res = a & b;
            8'h09: res = a | b;
            default: res = a ^ b;
        endcase
        n = res[7];
        z = (res == 8'd0);
        // compare leaves A alone but its flags still come from the difference
        if (row_op[r] == 8'hC9) begin
            res = a;
        end
        put_op_arg(8'hA2, row_x[r]);
        put_op_arg(8'hA9, a);
        put(row_carry[r] ? 8'h38 : 8'h18);
        put(8'h02);
        put_op_arg(row_op[r], b);
        put_abs(8'h8D, 16'h0200);
        put_op_arg(br_op, 8'h03);
        put_abs(8'h8E, 16'h0201);
        put_abs(8'h8D, 16'h02FF);
        put_abs(8'h4C, asm_pc);
        checker_inst.expect_write(16'h0200, res);
        if (!branch_taken(flag_sel, row_brval[r], n, v, c, z)) begin
            checker_inst.expect_write(16'h0201, row_x[r]);
        end
        checker_inst.expect_write(16'h02FF, res);
    endtask

    task automatic ctrl_program(input int r);
        logic [15:0] skip_at;
        logic [15:0] loop_at;
        logic [15:0] offset;
        put_op_arg(8'hA9, row_a[r]);
        skip_at = asm_pc + 16'd6;
        put_abs(8'h4C, skip_at);
        put_abs(8'h8D, 16'h0204);
        put(8'hFF);
        loop_at = asm_pc;
        put_op_arg(8'hA2, 8'h77);
        put_abs(8'h8E, 16'h0206);
        put_abs(8'h8D, 16'h0205);
        put(8'h18);
        put_op_arg(8'h69, 8'hFF);
        offset = loop_at - (asm_pc + 16'd2);
        put_op_arg(8'hD0, offset[7:0]);
        put_abs(8'h8D, 16'h02FF);
        put_abs(8'h4C, asm_pc);
        for (int i = int'(row_a[r]); i > 0; i--) begin
            checker_inst.expect_write(16'h0206, 8'h77);
            checker_inst.expect_write(16'h0205, 8'(i));
        end
        checker_inst.expect_write(16'h02FF, 8'h00);
    endtask

    task automatic build_table();
        string names [8] = '{"adc_a", "sbc_a", "and_a", "ora_a",
                             "eor_a", "cmp_a", "adc_b", "sbc_b"};
        logic [7:0] ops [8] = '{8'h69, 8'hE9, 8'h29, 8'h09,
                                8'h49, 8'hC9, 8'h69, 8'hE9};
        for (int r = 0; r < 8; r++) begin
            row_name[r]  = names[r];
            row_op[r]    = ops[r];
            row_kind[r]  = 0;
            row_a[r]     = rand_bits(8);
            row_b[r]     = rand_bits(8);
            row_x[r]     = rand_bits(8);
            row_carry[r] = (rand_bits(1) != 8'd0);
            row_brval[r] = (rand_bits(1) != 8'd0);
        end
        row_name[8] = "reg_store";
        row_kind[8] = 1;
        row_a[8]    = rand_bits(8);
        row_b[8]    = rand_bits(8);
        row_name[9] = "ctrl_flow";
        row_kind[9] = 2;
        row_a[9]    = 8'd1 + rand_bits(2);
    endtask

    //////////////////////////////////////////////////
    // test loop

    initial begin
        int    cycles;
        string test_name;
        reset_active = 1'b1;
        build_table();
        for (int pass = 0; pass < 2; pass++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (!timed_out) begin
                    @(negedge clock);
                    stall_mode   = 1'b0;
                    reset_active = 1'b1;
                    for (int i = 0; i < 65536; i++) begin
                        mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
                    end
                    asm_pc    = RESET_PC;
                    test_name = row_name[r];
                    if (pass == 1) begin
                        test_name = {test_name, "_stall"};
                    end
                    checker_inst.begin_test(test_name);
                    case (row_kind[r])
                        0: alu_program(r);
                        1: begin
                            put_op_arg(8'hA2, row_a[r]);
                            put_op_arg(8'hA0, row_b[r]);
                            put_abs(8'h8E, 16'h0202);
                            put_abs(8'h8C, 16'h0203);
                            put_abs(8'h8D, 16'h02FF);
                            put_abs(8'h4C, asm_pc);
                            checker_inst.expect_write(16'h0202, row_a[r]);
                            checker_inst.expect_write(16'h0203, row_b[r]);
                            checker_inst.expect_write(16'h02FF, 8'h00);
                        end
                        default: ctrl_program(r);
                    endcase
                    repeat (4) @(negedge clock);
                    reset_active        = 1'b0;
                    stall_mode          = (pass == 1);
                    checker_inst.active = 1'b1;
                    cycles = 0;
                    while (!checker_inst.marker_seen && cycles < TIMEOUT_CYCLES) begin
                        @(negedge clock);
                        cycles++;
                    end
                    if (!checker_inst.marker_seen) begin
                        timed_out = 1'b1;
                    end
                    checker_inst.finish_test(timed_out);
                end
            end
        end
        checker_inst.report_counts();
        if (checker_inst.fail_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_cpu_core
